// File: prf.f
+incdir+hw
hw/prf_pkg.sv
hw/prf_bank_ram.sv
hw/prf_read_arbiter.sv
hw/prf_wb_arbiter.sv
hw/prf.sv
bench/prf_properties.sv
bench/prf_tb.sv

// File: bench/prf_tb.sv
/*
 * prf_tb
 * random writebacks and reads against a reference register array,
 * with a separate compare process on the bus, forward and read ports
 */
`timescale 1ns/1ns
`default_nettype none
`include "prf_macros.svh"

module prf_tb;

    import prf_pkg::*;

    localparam int WR_PER_REQ = 12;
    localparam int RD_PER_REQ = 16;
    localparam int PHASE_TIMEOUT = 1000;

    // one accepted writeback stamped with its drive time
    typedef struct packed {
        logic [63:0] stamp;
        pr_t         pr;
        data_t       data;
        rob_index_t  rob;
    } wb_rec_t;

    logic                              CLK;
    logic                              nRST;
    logic [`PRF_RR_COUNT-1:0]          read_req_valid;
    pr_t [`PRF_RR_COUNT-1:0]           read_req_pr;
    logic [`PRF_RR_COUNT-1:0]          read_resp_ack;
    prf_port_e [`PRF_RR_COUNT-1:0]     read_resp_port;
    data_t [`PRF_BANK_COUNT-1:0][1:0]  read_data;
    logic [`PRF_WR_COUNT-1:0]          wb_valid;
    data_t [`PRF_WR_COUNT-1:0]         wb_data;
    pr_t [`PRF_WR_COUNT-1:0]           wb_pr;
    rob_index_t [`PRF_WR_COUNT-1:0]    wb_rob_index;
    logic [`PRF_WR_COUNT-1:0]          wb_ready;
    logic [`PRF_BANK_COUNT-1:0]        wb_bus_valid;
    data_t [`PRF_BANK_COUNT-1:0]       wb_bus_data;
    upper_pr_t [`PRF_BANK_COUNT-1:0]   wb_bus_upper_pr;
    rob_index_t [`PRF_BANK_COUNT-1:0]  wb_bus_rob_index;
    data_t [`PRF_BANK_COUNT-1:0]       forward_data;

    // state shared by stimulus and compare
    logic [31:0]               lfsr_state = 32'he3bf;
    data_t                     ref_regs [`PRF_PR_COUNT];
    wb_rec_t                   pend_q [`PRF_WR_COUNT][$];
    logic [`PRF_RR_COUNT-1:0]  rd_pending;
    pr_t                       rd_pr [`PRF_RR_COUNT];

    prf u_prf (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // --------------------
    // helpers

    // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // register 0 always reads zero
    function automatic data_t ref_read(input pr_t pr);
        return (pr == '0) ? data_t'(0) : ref_regs[pr];
    endfunction

    function automatic int writes_in_flight();
        int n;
        n = 0;
        for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
            n += pend_q[wr].size();
        end
        return n;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at %0t ns", $time);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s got %h expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_rob(input string name, input rob_index_t got, input rob_index_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s got %h expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_port(input string name, input prf_port_e got, input prf_port_e exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s got %s expected %s",
                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_bits(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    // --------------------
    // compare on the falling edge

    initial begin : compare
        wb_rec_t   rec;
        logic      found;
        bank_t     bk;
        int        ack_cnt [`PRF_BANK_COUNT];
        prf_port_e first_port [`PRF_BANK_COUNT];
        data_t     prev_bus [`PRF_BANK_COUNT];
        for (int r = 0; r < `PRF_PR_COUNT; r++) begin
            ref_regs[r] = '0;
        end
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            prev_bus[b] = '0;
        end
        forever begin
            @(negedge CLK);
            if (u_prf.u_prf_properties.fail_count != 0) begin
                report_failure("a bound assertion on the DUT failed");
            end
            if (nRST) begin
                for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
                    check_data($sformatf("forward_data[%0d]", b), forward_data[b], prev_bus[b]);
                    prev_bus[b] = wb_bus_data[b];
                    ack_cnt[b] = 0;
                    found = !wb_bus_valid[b];
                    // requesters own disjoint registers so only one queue front can match
                    for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
                        if (!found && pend_q[wr].size() > 0) begin
                            rec = pend_q[wr][0];
                            if (rec.stamp < $time && rec.pr == {wb_bus_upper_pr[b], bank_t'(b)})
                            begin
                                found = 1'b1;
                                check_data($sformatf("wb_bus_data[%0d]", b),
                                    wb_bus_data[b], rec.data);
                                check_rob($sformatf("wb_bus_rob_index[%0d]", b),
                                    wb_bus_rob_index[b], rec.rob);
                                ref_regs[rec.pr] = rec.data;
                                void'(pend_q[wr].pop_front());
                            end
                        end
                    end
                    if (!found) begin
                        report_failure($sformatf("bank %0d bus write to row %0d %s", b,
                            wb_bus_upper_pr[b], "matches no accepted writeback"));
                    end
                end
                // a write still held keeps its requester not ready
                for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
                    if (pend_q[wr].size() > 0 && pend_q[wr][0].stamp < $time) begin
                        check_bits($sformatf("wb_ready[%0d]", wr), 8'(wb_ready[wr]), 8'd0);
                    end
                end
                for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
                    if (read_resp_ack[rr]) begin
                        if (!rd_pending[rr]) begin
                            report_failure($sformatf("read requester %0d acked twice", rr));
                        end
                        bk = rd_pr[rr][`PRF_LOG_BANK_COUNT-1:0];
                        check_data($sformatf("read_data[%0d][%0d]", bk, read_resp_port[rr]),
                            read_data[bk][read_resp_port[rr]], ref_read(rd_pr[rr]));
                        if (ack_cnt[bk] == 1) begin
                            check_port($sformatf("read_resp_port[%0d]", rr), read_resp_port[rr],
                                (first_port[bk] == PORT0) ? PORT1 : PORT0);
                        end
                        first_port[bk] = read_resp_port[rr];
                        ack_cnt[bk]++;
                        if (ack_cnt[bk] > 2) begin
                            report_failure($sformatf("more than two read acks in bank %0d", bk));
                        end
                        rd_pending[rr] = 1'b0;
                    end
                end
            end
        end
    end

    // --------------------
    // stimulus on the falling edge

    initial begin : stimulus
        int      cycles;
        int      left;
        int      wr_sent [`PRF_WR_COUNT];
        int      rd_sent [`PRF_RR_COUNT];
        wb_rec_t rec;
        nRST = 1'b0;
        read_req_valid = '0;
        read_req_pr = '0;
        wb_valid = '0;
        wb_data = '0;
        wb_pr = '0;
        wb_rob_index = '0;
        rd_pending = '0;
        for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
            rd_pr[rr] = '0;
            rd_sent[rr] = 0;
        end
        for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
            wr_sent[wr] = 0;
        end
        repeat (4) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        check_bits("read_resp_ack", 8'(read_resp_ack), 8'd0);
        check_bits("wb_bus_valid", 8'(wb_bus_valid), 8'd0);
        check_bits("wb_ready", 8'(wb_ready), 8'({`PRF_WR_COUNT{1'b1}}));

        // writebacks where requester wr owns registers 16*wr to 16*wr+15
        cycles = 0;
        left = `PRF_WR_COUNT * WR_PER_REQ;
        while (left > 0) begin
            @(negedge CLK);
            wb_valid = '0;
            for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
                if (wb_ready[wr] && wr_sent[wr] < WR_PER_REQ) begin
                    rec.stamp = $time;
                    rec.pr = pr_t'(wr * 16 + rand_bits(4));
                    if (wr == 0 && wr_sent[0] == 0) begin
                        rec.pr = '0;
                    end
                    rec.data = rand_bits(32);
                    rec.rob = rob_index_t'(rand_bits(6));
                    wb_valid[wr] = 1'b1;
                    wb_pr[wr] = rec.pr;
                    wb_data[wr] = rec.data;
                    wb_rob_index[wr] = rec.rob;
                    // register 0 must never reach the bus
                    if (rec.pr != '0) begin
                        pend_q[wr].push_back(rec);
                    end
                    wr_sent[wr]++;
                    left--;
                end
            end
            cycles++;
            if (cycles > PHASE_TIMEOUT) begin
                report_failure("timeout: writeback requests were not all accepted");
            end
        end
        cycles = 0;
        do begin
            @(negedge CLK);
            wb_valid = '0;
            cycles++;
            if (cycles > PHASE_TIMEOUT) begin
                report_failure("timeout: accepted writebacks did not all reach the bus");
            end
        end while (writes_in_flight() > 0 || wb_ready != {`PRF_WR_COUNT{1'b1}});

        // random reads starting with register 0
        cycles = 0;
        left = `PRF_RR_COUNT * RD_PER_REQ;
        while (left > 0 || rd_pending != '0) begin
            @(negedge CLK);
            read_req_valid = '0;
            for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
                if (!rd_pending[rr] && rd_sent[rr] < RD_PER_REQ) begin
                    rd_pr[rr] = (rr == 0 && rd_sent[0] == 0) ? pr_t'(0) : pr_t'(rand_bits(6));
                    read_req_pr[rr] = rd_pr[rr];
                    read_req_valid[rr] = 1'b1;
                    rd_pending[rr] = 1'b1;
                    rd_sent[rr]++;
                    left--;
                end
            end
            cycles++;
            if (cycles > PHASE_TIMEOUT) begin
                report_failure("timeout: a read request was never acked");
            end
        end

        // all four requesters on bank 2 in the same cycle
        @(negedge CLK);
        for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
            rd_pr[rr] = pr_t'(rand_bits(4) * 4 + 2);
            read_req_pr[rr] = rd_pr[rr];
            read_req_valid[rr] = 1'b1;
            rd_pending[rr] = 1'b1;
        end
        cycles = 0;
        do begin
            @(negedge CLK);
            read_req_valid = '0;
            cycles++;
            if (cycles > 20) begin
                report_failure("timeout: contending reads on bank 2 were not all acked");
            end
        end while (rd_pending != '0);

        @(negedge CLK);
        @(posedge CLK);
        if (u_prf.u_prf_properties.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_failure("a bound assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

// File: bench/prf_properties.sv
/*
 * prf_properties
 * concurrent checks on the register file ports bound to prf
 */
`timescale 1ns/1ns
`default_nettype none
`include "prf_macros.svh"

module prf_properties (
    input wire logic                                     CLK,
    input wire logic                                     nRST,
    input wire logic [`PRF_RR_COUNT-1:0]                 read_resp_ack,
    input wire prf_pkg::prf_port_e [`PRF_RR_COUNT-1:0]   read_resp_port,
    input wire logic [`PRF_BANK_COUNT-1:0]               wb_bus_valid,
    input wire prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0] wb_bus_upper_pr,
    input wire prf_pkg::data_t [`PRF_BANK_COUNT-1:0]     wb_bus_data,
    input wire prf_pkg::data_t [`PRF_BANK_COUNT-1:0]     forward_data
);

    import prf_pkg::*;

    logic [`PRF_RR_COUNT-1:0] port1_bits;

    // count of failed assertions
    int fail_count = 0;

    always_comb begin
        for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
            port1_bits[rr] = (read_resp_port[rr] == PORT1);
        end
    end

    // port 1 only shows up next to an ack
    assert property (@(posedge CLK) disable iff (!nRST)
        (port1_bits & ~read_resp_ack) == '0)
        else begin
            fail_count++;
            $error("read port 1 reported without an ack");
        end

    // register 0 lives in bank 0 row 0
    assert property (@(posedge CLK) disable iff (!nRST)
        wb_bus_valid[0] |-> (wb_bus_upper_pr[0] != '0))
        else begin
            fail_count++;
            $error("writeback bus shows a write to register 0");
        end

    assert property (@(posedge CLK) disable iff (!nRST)
        forward_data == $past(wb_bus_data))
        else begin
            fail_count++;
            $error("forward data differs from the previous bus data");
        end

    assert property (@(posedge CLK)
        $rose(nRST) |-> (read_resp_ack == '0 && wb_bus_valid == '0))
        else begin
            fail_count++;
            $error("ack or bus valid set right after reset");
        end

endmodule

bind prf prf_properties u_prf_properties (
    .CLK             (CLK),
    .nRST            (nRST),
    .read_resp_ack   (read_resp_ack),
    .read_resp_port  (read_resp_port),
    .wb_bus_valid    (wb_bus_valid),
    .wb_bus_upper_pr (wb_bus_upper_pr),
    .wb_bus_data     (wb_bus_data),
    .forward_data    (forward_data)
);

`default_nettype wire

// File: hw/prf.sv
/*
 * prf
 * banked physical register file, 64 x 32 bits in four banks,
 * four read requesters and three writeback requesters
 */
`timescale 1ns/1ns
`default_nettype none
`include "prf_macros.svh"

module prf (
    input  wire logic                                       CLK,
    input  wire logic                                       nRST,
    input  wire logic [`PRF_RR_COUNT-1:0]                   read_req_valid,
    input  wire prf_pkg::pr_t [`PRF_RR_COUNT-1:0]           read_req_pr,
    output logic [`PRF_RR_COUNT-1:0]                        read_resp_ack,
    output prf_pkg::prf_port_e [`PRF_RR_COUNT-1:0]          read_resp_port,
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0][1:0]       read_data,
    input  wire logic [`PRF_WR_COUNT-1:0]                   wb_valid,
    input  wire prf_pkg::data_t [`PRF_WR_COUNT-1:0]         wb_data,
    input  wire prf_pkg::pr_t [`PRF_WR_COUNT-1:0]           wb_pr,
    input  wire prf_pkg::rob_index_t [`PRF_WR_COUNT-1:0]    wb_rob_index,
    output logic [`PRF_WR_COUNT-1:0]                        wb_ready,
    output logic [`PRF_BANK_COUNT-1:0]                      wb_bus_valid,
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0]            wb_bus_data,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]        wb_bus_upper_pr,
    output prf_pkg::rob_index_t [`PRF_BANK_COUNT-1:0]       wb_bus_rob_index,
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0]            forward_data
);

    import prf_pkg::*;

    upper_pr_t [`PRF_BANK_COUNT-1:0][1:0] read_row;

    prf_read_arbiter u_read_arbiter (
        .CLK            (CLK),
        .nRST           (nRST),
        .read_req_valid (read_req_valid),
        .read_req_pr    (read_req_pr),
        .read_resp_ack  (read_resp_ack),
        .read_resp_port (read_resp_port),
        .read_row       (read_row)
    );

    prf_wb_arbiter u_wb_arbiter (
        .CLK              (CLK),
        .nRST             (nRST),
        .wb_valid         (wb_valid),
        .wb_data          (wb_data),
        .wb_pr            (wb_pr),
        .wb_rob_index     (wb_rob_index),
        .wb_ready         (wb_ready),
        .wb_bus_valid     (wb_bus_valid),
        .wb_bus_data      (wb_bus_data),
        .wb_bus_upper_pr  (wb_bus_upper_pr),
        .wb_bus_rob_index (wb_bus_rob_index),
        .forward_data     (forward_data)
    );

    // the writeback bus is also the bank write port
    for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank
        prf_bank_ram u_bank_ram (
            .CLK        (CLK),
            .nRST       (nRST),
            .read_row   (read_row[b]),
            .read_data  (read_data[b]),
            .write_en   (wb_bus_valid[b]),
            .write_row  (wb_bus_upper_pr[b]),
            .write_data (wb_bus_data[b])
        );
    end

endmodule

`default_nettype wire

// File: hw/prf_wb_arbiter.sv
/*
 * prf_wb_arbiter
 * holds one pending writeback per requester, grants one write per
 * bank, drives the writeback bus and the delayed forward data
 */
`timescale 1ns/1ns
`default_nettype none
`include "prf_macros.svh"

module prf_wb_arbiter (
    input  wire logic                                   CLK,
    input  wire logic                                   nRST,
    input  wire logic [`PRF_WR_COUNT-1:0]               wb_valid,
    input  wire prf_pkg::data_t [`PRF_WR_COUNT-1:0]     wb_data,
    input  wire prf_pkg::pr_t [`PRF_WR_COUNT-1:0]       wb_pr,
    input  wire prf_pkg::rob_index_t [`PRF_WR_COUNT-1:0] wb_rob_index,
    output logic [`PRF_WR_COUNT-1:0]                    wb_ready,
    output logic [`PRF_BANK_COUNT-1:0]                  wb_bus_valid,
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0]        wb_bus_data,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0]    wb_bus_upper_pr,
    output prf_pkg::rob_index_t [`PRF_BANK_COUNT-1:0]   wb_bus_rob_index,
    output prf_pkg::data_t [`PRF_BANK_COUNT-1:0]        forward_data
);

    import prf_pkg::*;

    localparam int UPPER_W = $bits(upper_pr_t);

    // oldest unaccepted write per requester
    logic [`PRF_WR_COUNT-1:0]                      held_valid;
    logic [`PRF_WR_COUNT-1:0]                      held_valid_next;
    data_t [`PRF_WR_COUNT-1:0]                     held_data;
    pr_t [`PRF_WR_COUNT-1:0]                       held_pr;
    rob_index_t [`PRF_WR_COUNT-1:0]                held_rob;

    logic [`PRF_WR_COUNT-1:0]                      merged_valid;
    data_t [`PRF_WR_COUNT-1:0]                     merged_data;
    pr_t [`PRF_WR_COUNT-1:0]                       merged_pr;
    rob_index_t [`PRF_WR_COUNT-1:0]                merged_rob;

    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] bank_req;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] grant;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] mask;
    logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] mask_next;
    req_vec_t [`PRF_BANK_COUNT-1:0]                masked_pick;
    req_vec_t [`PRF_BANK_COUNT-1:0]                full_pick;
    logic [`PRF_WR_COUNT-1:0]                      ack;

    logic [`PRF_BANK_COUNT-1:0]                    bus_valid_next;
    data_t [`PRF_BANK_COUNT-1:0]                   bus_data_next;
    upper_pr_t [`PRF_BANK_COUNT-1:0]               bus_row_next;
    rob_index_t [`PRF_BANK_COUNT-1:0]              bus_rob_next;

    // --------------------
    // merge

    // new input is ignored while a write is held
    always_comb begin
        for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
            merged_valid[wr] = held_valid[wr] | wb_valid[wr];
            merged_data[wr] = held_valid[wr] ? held_data[wr] : wb_data[wr];
            merged_pr[wr] = held_valid[wr] ? held_pr[wr] : wb_pr[wr];
            merged_rob[wr] = held_valid[wr] ? held_rob[wr] : wb_rob_index[wr];
        end
    end

    // --------------------
    // one write per bank

    always_comb begin
        ack = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
                bank_req[b][wr] = merged_valid[wr]
                    && (merged_pr[wr][`PRF_LOG_BANK_COUNT-1:0] == bank_t'(b));
            end

            masked_pick[b] = pick_lowest(req_vec_t'(bank_req[b] & mask[b]));
            full_pick[b] = pick_lowest(req_vec_t'(bank_req[b]));
            if (|(bank_req[b] & mask[b])) begin
                grant[b] = masked_pick[b][`PRF_WR_COUNT-1:0];
            end else begin
                grant[b] = full_pick[b][`PRF_WR_COUNT-1:0];
            end

            mask_next[b] = ~(grant[b] | (grant[b] - 1'b1));
            ack |= grant[b];
        end

        held_valid_next = merged_valid & ~ack;
    end

    // one-hot mux onto the bus
    always_comb begin
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            bus_valid_next[b] = |grant[b];
            bus_data_next[b] = '0;
            bus_row_next[b] = '0;
            bus_rob_next[b] = '0;
            for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
                bus_data_next[b] |= merged_data[wr] & {`PRF_DATA_WIDTH{grant[b][wr]}};
                bus_row_next[b] |= merged_pr[wr][`PRF_LOG_PR_COUNT-1:`PRF_LOG_BANK_COUNT]
                    & {UPPER_W{grant[b][wr]}};
                bus_rob_next[b] |= merged_rob[wr] & {`PRF_ROB_INDEX_WIDTH{grant[b][wr]}};
            end
        end

        // register 0 is bank 0 row 0, granted but never written
        if (bus_row_next[0] == '0) begin
            bus_valid_next[0] = 1'b0;
        end
    end

    assign wb_ready = ~held_valid;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            held_valid <= '0;
            mask <= '0;
            wb_bus_valid <= '0;
            wb_bus_data <= '0;
            wb_bus_upper_pr <= '0;
            wb_bus_rob_index <= '0;
            forward_data <= '0;
        end else begin
            held_valid <= held_valid_next;
            mask <= mask_next;
            wb_bus_valid <= bus_valid_next;
            wb_bus_data <= bus_data_next;
            wb_bus_upper_pr <= bus_row_next;
            wb_bus_rob_index <= bus_rob_next;
            // one cycle after the bus, the cycle consumers pick it up
            forward_data <= wb_bus_data;
        end
    end

    always_ff @(posedge CLK) begin
        held_data <= merged_data;
        held_pr <= merged_pr;
        held_rob <= merged_rob;
    end

endmodule

`default_nettype wire

// File: hw/prf_read_arbiter.sv
/*
 * prf_read_arbiter
 * holds unacked read requests, picks two per bank under a rotating
 * mask and returns registered acks, port numbers and RAM rows
 */
`timescale 1ns/1ns
`default_nettype none
`include "prf_macros.svh"

module prf_read_arbiter (
    input  wire logic                                           CLK,
    input  wire logic                                           nRST,
    input  wire logic [`PRF_RR_COUNT-1:0]                       read_req_valid,
    input  wire prf_pkg::pr_t [`PRF_RR_COUNT-1:0]               read_req_pr,
    output logic [`PRF_RR_COUNT-1:0]                            read_resp_ack,
    output prf_pkg::prf_port_e [`PRF_RR_COUNT-1:0]              read_resp_port,
    output prf_pkg::upper_pr_t [`PRF_BANK_COUNT-1:0][1:0]       read_row
);

    import prf_pkg::*;

    localparam int UPPER_W = $bits(upper_pr_t);

    // held requests
    logic [`PRF_RR_COUNT-1:0]                     held_valid;
    logic [`PRF_RR_COUNT-1:0]                     held_valid_next;
    pr_t [`PRF_RR_COUNT-1:0]                      held_pr;

    // new and held requests together
    logic [`PRF_RR_COUNT-1:0]                     merged_valid;
    pr_t [`PRF_RR_COUNT-1:0]                      merged_pr;

    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] bank_req;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] grant0;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] grant1;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] mask;
    logic [`PRF_BANK_COUNT-1:0][`PRF_RR_COUNT-1:0] mask_next;

    logic [`PRF_RR_COUNT-1:0]                     ack_next;
    logic [`PRF_RR_COUNT-1:0]                     port1_hit;
    prf_port_e [`PRF_RR_COUNT-1:0]                port_next;
    upper_pr_t [`PRF_BANK_COUNT-1:0][1:0]         row_next;

    // --------------------
    // merge and steer

    // a held request wins over the input slot
    always_comb begin
        for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
            merged_valid[rr] = held_valid[rr] | read_req_valid[rr];
            merged_pr[rr] = held_valid[rr] ? held_pr[rr] : read_req_pr[rr];
        end
    end

    // --------------------
    // per bank selection

    always_comb begin
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
                bank_req[b][rr] = merged_valid[rr]
                    && (merged_pr[rr][`PRF_LOG_BANK_COUNT-1:0] == bank_t'(b));
            end

            // port 0 prefers requesters above the last port 1 grant
            if (|(bank_req[b] & mask[b])) begin
                grant0[b] = pick_lowest(bank_req[b] & mask[b]);
            end else begin
                grant0[b] = pick_lowest(bank_req[b]);
            end

            // port 1 over what port 0 left
            if (|(bank_req[b] & ~grant0[b] & mask[b])) begin
                grant1[b] = pick_lowest(bank_req[b] & ~grant0[b] & mask[b]);
            end else begin
                grant1[b] = pick_lowest(bank_req[b] & ~grant0[b]);
            end

            // bits strictly above the port 1 grant or empty without one
            mask_next[b] = ~(grant1[b] | (grant1[b] - 1'b1));
        end
    end

    // --------------------
    // responses and rows

    always_comb begin
        ack_next = '0;
        port1_hit = '0;
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            ack_next |= grant0[b] | grant1[b];
            port1_hit |= grant1[b];
        end

        for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
            port_next[rr] = port1_hit[rr] ? PORT1 : PORT0;
        end

        held_valid_next = merged_valid & ~ack_next;

        // one-hot mux of the row bits
        for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
            row_next[b][0] = '0;
            row_next[b][1] = '0;
            for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
                row_next[b][0] |= merged_pr[rr][`PRF_LOG_PR_COUNT-1:`PRF_LOG_BANK_COUNT]
                    & {UPPER_W{grant0[b][rr]}};
                row_next[b][1] |= merged_pr[rr][`PRF_LOG_PR_COUNT-1:`PRF_LOG_BANK_COUNT]
                    & {UPPER_W{grant1[b][rr]}};
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            read_resp_ack <= '0;
            for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
                read_resp_port[rr] <= PORT0;
            end
            read_row <= '0;
            held_valid <= '0;
            mask <= '0;
        end else begin
            read_resp_ack <= ack_next;
            read_resp_port <= port_next;
            read_row <= row_next;
            held_valid <= held_valid_next;
            mask <= mask_next;
        end
    end

    // register number of each held request
    always_ff @(posedge CLK) begin
        held_pr <= merged_pr;
    end

endmodule

`default_nettype wire

// File: hw/prf_bank_ram.sv
/*
 * prf_bank_ram
 * storage of one register bank, two combinational read ports
 * and one clocked write port
 */
`timescale 1ns/1ns
`default_nettype none
`include "prf_macros.svh"

module prf_bank_ram (
    input  wire logic                     CLK,
    input  wire logic                     nRST,
    input  wire prf_pkg::upper_pr_t [1:0] read_row,
    output prf_pkg::data_t [1:0]          read_data,
    input  wire logic                     write_en,
    input  wire prf_pkg::upper_pr_t       write_row,
    input  wire prf_pkg::data_t           write_data
);

    import prf_pkg::*;

    localparam int ROW_COUNT = `PRF_PR_COUNT / `PRF_BANK_COUNT;

    data_t mem [ROW_COUNT];

    // both ports see the array directly
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            read_data[p] = mem[read_row[p]];
        end
    end

    // all rows start at zero so register 0 reads zero
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < ROW_COUNT; r++) begin
                mem[r] <= '0;
            end
        end else if (write_en) begin
            mem[write_row] <= write_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/prf_pkg.sv
/*
 * prf_pkg
 * shared types of the banked register file and the
 * lowest-set-bit picker used by both arbiters
 */
`default_nettype none
`include "prf_macros.svh"

package prf_pkg;

    typedef logic [`PRF_LOG_PR_COUNT-1:0] pr_t;
    typedef logic [`PRF_LOG_BANK_COUNT-1:0] bank_t;
    typedef logic [`PRF_LOG_PR_COUNT-`PRF_LOG_BANK_COUNT-1:0] upper_pr_t;
    typedef logic [`PRF_DATA_WIDTH-1:0] data_t;
    typedef logic [`PRF_ROB_INDEX_WIDTH-1:0] rob_index_t;

    // read port within a bank
    typedef enum logic {
        PORT0 = 1'b0,
        PORT1 = 1'b1
    } prf_port_e;

    // sized for the wider requester group
    typedef logic [`PRF_RR_COUNT-1:0] req_vec_t;

    // one-hot of the lowest set bit, zero when nothing requests
    function automatic req_vec_t pick_lowest(input req_vec_t req);
        return req & (~req + 1'b1);
    endfunction

endpackage

`default_nettype wire

// File: hw/prf_macros.svh
/*
 * prf sizes
 * register count, bank split, requester counts and field widths
 * of the banked physical register file
 */
`ifndef PRF_MACROS_SVH
`define PRF_MACROS_SVH

// register array
`define PRF_PR_COUNT 64
`define PRF_LOG_PR_COUNT 6
`define PRF_DATA_WIDTH 32

// banking, low bits of the register number pick the bank
`define PRF_BANK_COUNT 4
`define PRF_LOG_BANK_COUNT 2

// requesters
`define PRF_RR_COUNT 4
`define PRF_WR_COUNT 3

// reorder buffer
`define PRF_ROB_INDEX_WIDTH 6

`endif
